//--- dv/programTests.txt
# P <imem word index hex> <instruction hex>; W <register decimal> <value hex>
# S <byte address hex> <value hex>; W and S records are in program order
P 00 20010005  # addi $1, $0, 5
P 01 2002FFFD  # addi $2, $0, -3
P 02 20037FFF  # addi $3, $0, 0x7fff
P 03 00012700  # sll  $4, $1, 28 (write-through of $1)
P 04 00222820  # add  $5, $1, $2
P 05 00233022  # sub  $6, $1, $3
P 06 00843821  # addu $7, $4, $4
P 07 00414023  # subu $8, $2, $1
P 08 00434824  # and  $9, $2, $3
P 09 00815025  # or   $10, $4, $1
P 0a 0041582A  # slt  $11, $2, $1
P 0b 0041602B  # sltu $12, $2, $1
P 0c 00E76820  # add  $13, $7, $7 (wraps)
P 0d 20200007  # addi $0, $1, 7 (no writeback)
P 0e 00017022  # sub  $14, $0, $1
P 0f AC25001B  # sw   $5, 0x1b($1)
P 10 AC26FFFF  # sw   $6, -1($1)
P 11 8C2F001B  # lw   $15, 0x1b($1)
P 12 8C30FFFF  # lw   $16, -1($1)
P 13 10220002  # beq  $1, $2, +2 (not taken)
P 14 14210002  # bne  $1, $1, +2 (not taken)
P 15 1C400002  # bgtz $2, +2 (negative, not taken)
P 16 1C000002  # bgtz $0, +2 (zero, not taken)
P 17 21F10001  # addi $17, $15, 1
P 18 11E50002  # beq  $15, $5, +2 (taken)
P 19 20120011  # addi $18, $0, 0x11 (squashed)
P 1a AC010000  # sw   $1, 0($0) (squashed)
P 1b 20130021  # addi $19, $0, 0x21
P 1c 14220002  # bne  $1, $2, +2 (taken)
P 1d 20120022  # addi $18, $0, 0x22 (squashed)
P 1e 20120033  # addi $18, $0, 0x33 (squashed)
P 1f 20140031  # addi $20, $0, 0x31
P 20 1C200002  # bgtz $1, +2 (positive, taken)
P 21 20120044  # addi $18, $0, 0x44 (squashed)
P 22 AC010000  # sw   $1, 0($0) (squashed)
P 23 22320010  # addi $18, $17, 0x10
P 24 1000FFFF  # beq  $0, $0, -1 (spin here)
W 1 00000005
W 2 fffffffd
W 3 00007fff
W 4 50000000
W 5 00000002
W 6 ffff8006
W 7 a0000000
W 8 fffffff8
W 9 00007ffd
W 10 50000005
W 11 00000001
W 12 00000000
W 13 40000000
W 14 fffffffb
W 15 00000002
W 16 ffff8006
W 17 00000003
W 19 00000021
W 20 00000031
W 18 00000013
S 00000020 00000002
S 00000004 ffff8006

//--- verilog.f
design/isaPkg.sv
design/pipePkg.sv
design/pipeBuses.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/mipsPipeTop.sv
dv/mipsPipeTb.sv

//--- Makefile
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 -f verilog.f --top-module mipsPipeTb
	./obj_dir/VmipsPipeTb | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module mipsPipeTop

clean:
	rm -rf obj_dir $(LOG)

//--- dv/mipsPipeTb.sv
// Testbench that loads the MIPS program from the tests file and checks the writeback and store traces
`timescale 1ns/10ps

module mipsPipeTb;

	logic clk;
	logic rstN;
	logic loadEn;
	pipePkg::imemAddr loadAddr;
	isaPkg::word loadData;
	logic wbValid;
	isaPkg::regIdx wbReg;
	isaPkg::word wbData;
	logic storeValid;
	isaPkg::word storeAddr;
	isaPkg::word storeData;

	// Program image and expected traces from the data file
	pipePkg::imemAddr progAddr[$];
	isaPkg::word progWord[$];
	isaPkg::regIdx wbRegExp[$];
	isaPkg::word wbDataExp[$];
	isaPkg::word stAddrExp[$];
	isaPkg::word stDataExp[$];
	int wbSeen;
	int stSeen;

	mipsPipeTop i_dut (
		.clk, .rstN, .loadEn, .loadAddr, .loadData,
		.wbValid, .wbReg, .wbData,
		.storeValid, .storeAddr, .storeData
	);

	always #2 clk = ~clk;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWb(input isaPkg::regIdx expReg, input isaPkg::word expData);
		if (wbReg !== expReg || wbData !== expData) begin
			abortRun($sformatf("ERROR at %0t: writeback %0d expected r%0d=%h, got r%0d=%h",
				$time, wbSeen, expReg, expData, wbReg, wbData));
		end
	endtask

	task automatic checkStore(input isaPkg::word expAddr, input isaPkg::word expData);
		if (storeAddr !== expAddr || storeData !== expData) begin
			abortRun($sformatf("ERROR at %0t: store %0d expected [%h]=%h, got [%h]=%h",
				$time, stSeen, expAddr, expData, storeAddr, storeData));
		end
	endtask

	// One tagged record per line with # starting a comment
	task automatic readTests();
		int fd;
		int code;
		int ch;
		logic [7:0] tag;
		isaPkg::word a;
		isaPkg::word v;
		fd = $fopen("dv/programTests.txt", "r");
		if (fd == 0) begin
			abortRun("could not open dv/programTests.txt");
		end
		while ($fscanf(fd, " %c", tag) == 1) begin
			if (tag == "#") begin
				ch = $fgetc(fd);
				while (ch != "\n" && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else begin
				code = (tag == "W") ? $fscanf(fd, "%d %h", a, v) : $fscanf(fd, "%h %h", a, v);
				if (code != 2) begin
					abortRun("malformed record in the tests file");
				end
				case (tag)
					"P": begin
						progAddr.push_back(pipePkg::imemAddr'(a));
						progWord.push_back(v);
					end
					"W": begin
						wbRegExp.push_back(isaPkg::regIdx'(a));
						wbDataExp.push_back(v);
					end
					"S": begin
						stAddrExp.push_back(a);
						stDataExp.push_back(v);
					end
					default: abortRun("unknown record tag in the tests file");
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic loadProgram();
		foreach (progWord[i]) begin
			@(posedge clk);
			loadEn   <= 1'b1;
			loadAddr <= progAddr[i];
			loadData <= progWord[i];
		end
		@(posedge clk);
		loadEn <= 1'b0;
	endtask

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		while (wbSeen < wbRegExp.size() || stSeen < stAddrExp.size()) begin
			if (cycles == 400) begin
				abortRun("timeout waiting for expected writebacks or stores");
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	// Strobe monitor sampling on the falling edge
	always @(negedge clk) begin
		if (wbValid === 1'b1) begin
			if (wbSeen >= wbRegExp.size()) begin
				abortRun($sformatf("unexpected writeback to r%0d at %0t", wbReg, $time));
			end else begin
				checkWb(wbRegExp[wbSeen], wbDataExp[wbSeen]);
				wbSeen++;
			end
		end
		if (storeValid === 1'b1) begin
			if (stSeen >= stAddrExp.size()) begin
				abortRun($sformatf("unexpected store to %h at %0t", storeAddr, $time));
			end else begin
				checkStore(stAddrExp[stSeen], stDataExp[stSeen]);
				stSeen++;
			end
		end
	end

	initial begin
		clk      = 1'b0;
		rstN     = 1'b0;
		loadEn   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		wbSeen   = 0;
		stSeen   = 0;
		readTests();
		loadProgram();
		// Reset stays low for ten cycles once the program is in
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		waitDrained();
		// Quiet period to catch stray pulses
		repeat (20) @(posedge clk);
		$display("Everything OK");
		$finish;
	end

endmodule

//--- design/mipsPipeTop.sv
// Top level of the five-stage MIPS pipeline; load port in, writeback and store strobes out
`timescale 1ns/10ps

module mipsPipeTop (
	input  logic             clk,
	input  logic             rstN,
	input  logic             loadEn,
	input  pipePkg::imemAddr loadAddr,
	input  isaPkg::word      loadData,
	output logic             wbValid,
	output isaPkg::regIdx    wbReg,
	output isaPkg::word      wbData,
	output logic             storeValid,
	output isaPkg::word      storeAddr,
	output isaPkg::word      storeData
);

	isaPkg::word inst, instPc, branchTarget;
	logic instValid, branchTaken;

	decExBus decBus ();
	exMemBus exmBus ();
	wbBus    wbB ();

	fetchStage uFetch (
		.clk, .rstN, .loadEn, .loadAddr, .loadData,
		.branchTaken, .branchTarget,
		.inst, .instPc, .instValid
	);

	// The branch pulse also squashes the slot leaving decode
	decodeStage uDecode (
		.clk, .rstN, .inst, .instPc, .instValid,
		.flush(branchTaken), .wb(wbB), .dec(decBus)
	);

	executeStage uExecute (
		.clk, .rstN, .dec(decBus), .exm(exmBus),
		.branchTaken, .branchTarget
	);

	memWbStage uMemWb (
		.clk, .rstN, .exm(exmBus), .wb(wbB),
		.wbValid, .wbReg, .wbData,
		.storeValid, .storeAddr, .storeData
	);

endmodule

//--- design/memWbStage.sv
// Memory and writeback: data memory, memory/writeback register and the observation strobes
`timescale 1ns/10ps

module memWbStage (
	input  logic          clk,
	input  logic          rstN,
	exMemBus.dst          exm,
	wbBus.src             wb,
	output logic          wbValid,
	output isaPkg::regIdx wbReg,
	output isaPkg::word   wbData,
	output logic          storeValid,
	output isaPkg::word   storeAddr,
	output isaPkg::word   storeData
);

	isaPkg::word dmem [pipePkg::DMEM_WORDS];
	pipePkg::dmemAddr addr;
	isaPkg::word loadData;
	logic memWe;
	logic regWrQ;
	isaPkg::regIdx rwQ;
	isaPkg::word busWQ;

	// Word addressed, byte offset ignored
	assign addr  = exm.aluOut[9:2];
	assign memWe = exm.valid && exm.memWr;

	always_ff @(posedge clk) begin
		if (memWe) begin
			dmem[addr] <= exm.storeData;
		end
	end

	assign loadData = dmem[addr];

	// Store strobe mirrors the write above
	assign storeValid = memWe;
	assign storeAddr  = exm.aluOut;
	assign storeData  = exm.storeData;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			regWrQ <= 1'b0;
		end else begin
			regWrQ <= exm.valid && exm.regWr;
		end
	end

	always_ff @(posedge clk) begin
		rwQ   <= exm.rw;
		busWQ <= exm.memToReg ? loadData : exm.aluOut;
	end

	assign wb.regWr = regWrQ;
	assign wb.rw    = rwQ;
	assign wb.busW  = busWQ;

	assign wbValid = regWrQ;
	assign wbReg   = rwQ;
	assign wbData  = busWQ;

endmodule

//--- design/executeStage.sv
// Execute stage: ALU, operand select, branch resolution and the execute/memory register
`timescale 1ns/10ps

module executeStage (
	input  logic        clk,
	input  logic        rstN,
	decExBus.dst        dec,
	exMemBus.src        exm,
	output logic        branchTaken,
	output isaPkg::word branchTarget
);

	isaPkg::word immExt, opB, aluOut;
	isaPkg::regIdx rw;
	logic brCond;

	assign immExt = dec.signExt ? {{16{dec.imm[15]}}, dec.imm[15:0]} : {16'b0, dec.imm[15:0]};
	assign opB    = dec.aluSrcImm ? immExt : dec.busB;

	// add and sub simply wrap, no overflow trap
	always_comb begin
		case (dec.aluOp)
			pipePkg::ALU_AND:  aluOut = dec.busA & opB;
			pipePkg::ALU_OR:   aluOut = dec.busA | opB;
			pipePkg::ALU_ADD:  aluOut = dec.busA + opB;
			pipePkg::ALU_SUB:  aluOut = dec.busA - opB;
			pipePkg::ALU_SLT:  aluOut = {31'b0, $signed(dec.busA) < $signed(opB)};
			pipePkg::ALU_SLTU: aluOut = {31'b0, dec.busA < opB};
			pipePkg::ALU_SLL:  aluOut = dec.busB << dec.shamt;
			default:           aluOut = '0;
		endcase
	end

	assign rw = dec.regDst ? dec.rd : dec.rt;

	always_comb begin
		case (dec.brKind)
			pipePkg::BR_EQ:  brCond = (dec.busA == dec.busB);
			pipePkg::BR_NE:  brCond = (dec.busA != dec.busB);
			pipePkg::BR_GTZ: brCond = ($signed(dec.busA) > 0);
			default:         brCond = 1'b0;
		endcase
	end

	// Target was already made absolute in decode
	assign branchTaken  = dec.valid && brCond;
	assign branchTarget = dec.imm;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exm.valid    <= 1'b0;
			exm.memWr    <= 1'b0;
			exm.memToReg <= 1'b0;
			exm.regWr    <= 1'b0;
		end else begin
			exm.valid    <= dec.valid;
			exm.memWr    <= dec.valid && dec.memWr;
			exm.memToReg <= dec.valid && dec.memToReg;
			exm.regWr    <= dec.valid && dec.regWr;
		end
	end

	always_ff @(posedge clk) begin
		exm.aluOut    <= aluOut;
		exm.storeData <= dec.busB;
		exm.rw        <= rw;
	end

endmodule

//--- design/decodeStage.sv
// Decode stage: control generation, register file with write-through, decode/execute register
`timescale 1ns/10ps

module decodeStage (
	input  logic        clk,
	input  logic        rstN,
	input  isaPkg::word inst,
	input  isaPkg::word instPc,
	input  logic        instValid,
	input  logic        flush,
	wbBus.dst           wb,
	decExBus.src        dec
);

	isaPkg::opcode op;
	isaPkg::funct fn;
	isaPkg::regIdx rs, rt, rd, dest;
	isaPkg::imm16 immField;
	isaPkg::word busA, busB, brTarget;
	isaPkg::word regs [32];

	pipePkg::aluCtrl ctlAluOp;
	pipePkg::brKind brSel;
	logic ctlAluSrcImm, ctlSignExt, ctlRegDst, ctlMemWr, ctlMemToReg, ctlRegWr;
	logic live;

	assign op       = inst[31:26];
	assign rs       = inst[25:21];
	assign rt       = inst[20:16];
	assign rd       = inst[15:11];
	assign immField = inst[15:0];
	assign fn       = inst[5:0];

	// Slot survives only if fetched and not squashed by a branch in execute
	assign live = instValid && !flush;

	always_comb begin
		ctlAluOp     = pipePkg::ALU_ADD;
		ctlAluSrcImm = 1'b0;
		ctlSignExt   = 1'b0;
		ctlRegDst    = 1'b0;
		ctlMemWr     = 1'b0;
		ctlMemToReg  = 1'b0;
		ctlRegWr     = 1'b0;
		brSel        = pipePkg::BR_NONE;
		case (op)
			isaPkg::OP_RTYPE: begin
				ctlRegDst = 1'b1;
				ctlRegWr  = 1'b1;
				case (fn)
					isaPkg::FN_ADD, isaPkg::FN_ADDU: ctlAluOp = pipePkg::ALU_ADD;
					isaPkg::FN_SUB, isaPkg::FN_SUBU: ctlAluOp = pipePkg::ALU_SUB;
					isaPkg::FN_AND:  ctlAluOp = pipePkg::ALU_AND;
					isaPkg::FN_OR:   ctlAluOp = pipePkg::ALU_OR;
					isaPkg::FN_SLL:  ctlAluOp = pipePkg::ALU_SLL;
					isaPkg::FN_SLT:  ctlAluOp = pipePkg::ALU_SLT;
					isaPkg::FN_SLTU: ctlAluOp = pipePkg::ALU_SLTU;
					default:         ctlRegWr = 1'b0;
				endcase
			end
			isaPkg::OP_ADDI: begin
				ctlAluSrcImm = 1'b1;
				ctlSignExt   = 1'b1;
				ctlRegWr     = 1'b1;
			end
			isaPkg::OP_LW: begin
				ctlAluSrcImm = 1'b1;
				ctlSignExt   = 1'b1;
				ctlMemToReg  = 1'b1;
				ctlRegWr     = 1'b1;
			end
			isaPkg::OP_SW: begin
				ctlAluSrcImm = 1'b1;
				ctlSignExt   = 1'b1;
				ctlMemWr     = 1'b1;
			end
			isaPkg::OP_BEQ:  brSel = pipePkg::BR_EQ;
			isaPkg::OP_BNE:  brSel = pipePkg::BR_NE;
			isaPkg::OP_BGTZ: brSel = pipePkg::BR_GTZ;
			default: ;
		endcase
	end

	// Register 0 is never written, so the enable drops here
	assign dest = ctlRegDst ? rd : rt;

	// PC-relative offset resolved to an absolute address
	assign brTarget = instPc + 32'd4 + {{14{immField[15]}}, immField, 2'b00};

	always_ff @(posedge clk) begin
		if (wb.regWr) begin
			regs[wb.rw] <= wb.busW;
		end
	end

	// Reads see a writeback landing in the same cycle
	assign busA = (rs == '0) ? '0 : (wb.regWr && wb.rw == rs) ? wb.busW : regs[rs];
	assign busB = (rt == '0) ? '0 : (wb.regWr && wb.rw == rt) ? wb.busW : regs[rt];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dec.valid    <= 1'b0;
			dec.regWr    <= 1'b0;
			dec.memWr    <= 1'b0;
			dec.memToReg <= 1'b0;
			dec.brKind   <= pipePkg::BR_NONE;
		end else begin
			dec.valid    <= live;
			dec.regWr    <= live && ctlRegWr && (dest != '0);
			dec.memWr    <= live && ctlMemWr;
			dec.memToReg <= live && ctlMemToReg;
			dec.brKind   <= live ? brSel : pipePkg::BR_NONE;
		end
	end

	always_ff @(posedge clk) begin
		dec.aluOp     <= ctlAluOp;
		dec.aluSrcImm <= ctlAluSrcImm;
		dec.signExt   <= ctlSignExt;
		dec.regDst    <= ctlRegDst;
		dec.busA      <= busA;
		dec.busB      <= busB;
		dec.imm       <= (brSel != pipePkg::BR_NONE) ? brTarget : {16'b0, immField};
		dec.shamt     <= inst[10:6];
		dec.rt        <= rt;
		dec.rd        <= rd;
	end

endmodule

//--- design/fetchStage.sv
// Fetch stage: PC, loadable instruction memory and the fetch/decode register
`timescale 1ns/10ps

module fetchStage (
	input  logic              clk,
	input  logic              rstN,
	input  logic              loadEn,
	input  pipePkg::imemAddr  loadAddr,
	input  isaPkg::word       loadData,
	input  logic              branchTaken,
	input  isaPkg::word       branchTarget,
	output isaPkg::word       inst,
	output isaPkg::word       instPc,
	output logic              instValid
);

	isaPkg::word imem [pipePkg::IMEM_WORDS];
	isaPkg::word pc;
	pipePkg::imemAddr pcIdx;

	// Word index of the current PC
	assign pcIdx = pc[9:2];

	// Program load, only while held in reset
	always_ff @(posedge clk) begin
		if (!rstN && loadEn) begin
			imem[loadAddr] <= loadData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (branchTaken) begin
			pc <= branchTarget;
		end else begin
			pc <= pc + 32'd4;
		end
	end

	// A taken branch kills the word being fetched now
	always_ff @(posedge clk) begin
		if (!rstN) begin
			instValid <= 1'b0;
		end else begin
			instValid <= !branchTaken;
		end
	end

	always_ff @(posedge clk) begin
		inst   <= imem[pcIdx];
		instPc <= pc;
	end

endmodule

//--- design/pipeBuses.sv
// Stage-to-stage bundles; each stage drives its src modport and the next stage reads dst
`timescale 1ns/10ps

// Decode to execute: control bits plus operands
interface decExBus;
	logic valid;
	pipePkg::aluCtrl aluOp;
	logic aluSrcImm;
	logic signExt;
	logic regDst;
	logic memWr;
	logic memToReg;
	logic regWr;
	pipePkg::brKind brKind;
	isaPkg::word busA;
	isaPkg::word busB;
	// Low half is imm16, or the whole word is a branch target
	isaPkg::word imm;
	logic [4:0] shamt;
	isaPkg::regIdx rt;
	isaPkg::regIdx rd;

	modport src (output valid, aluOp, aluSrcImm, signExt, regDst, memWr, memToReg, regWr,
		brKind, busA, busB, imm, shamt, rt, rd);
	modport dst (input valid, aluOp, aluSrcImm, signExt, regDst, memWr, memToReg, regWr,
		brKind, busA, busB, imm, shamt, rt, rd);
endinterface

// Execute to memory
interface exMemBus;
	logic valid;
	isaPkg::word aluOut;
	isaPkg::word storeData;
	isaPkg::regIdx rw;
	logic memWr;
	logic memToReg;
	logic regWr;

	modport src (output valid, aluOut, storeData, rw, memWr, memToReg, regWr);
	modport dst (input valid, aluOut, storeData, rw, memWr, memToReg, regWr);
endinterface

// Writeback into the register file
interface wbBus;
	logic regWr;
	isaPkg::regIdx rw;
	isaPkg::word busW;

	modport src (output regWr, rw, busW);
	modport dst (input regWr, rw, busW);
endinterface

//--- design/pipePkg.sv
// Pipeline-internal control codes and memory sizes used by the stages, the buses and the top level
package pipePkg;

	// ALU operation select
	typedef logic [2:0] aluCtrl;

	localparam aluCtrl ALU_AND  = 3'd0;
	localparam aluCtrl ALU_OR   = 3'd1;
	localparam aluCtrl ALU_ADD  = 3'd2;
	localparam aluCtrl ALU_SLT  = 3'd3;
	localparam aluCtrl ALU_SLL  = 3'd5;
	localparam aluCtrl ALU_SUB  = 3'd6;
	localparam aluCtrl ALU_SLTU = 3'd7;

	// Branch condition carried to execute
	typedef logic [1:0] brKind;

	localparam brKind BR_NONE = 2'd0;
	localparam brKind BR_EQ   = 2'd1;
	localparam brKind BR_NE   = 2'd2;
	localparam brKind BR_GTZ  = 2'd3;

	// Memory depths in words
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;

	typedef logic [$clog2(IMEM_WORDS)-1:0] imemAddr;
	typedef logic [$clog2(DMEM_WORDS)-1:0] dmemAddr;

endpackage

//--- design/isaPkg.sv
// Instruction-set encodings and word types for the MIPS subset, shared by decode and the testbench
package isaPkg;

	// Basic machine values
	typedef logic [31:0] word;
	typedef logic [4:0]  regIdx;
	typedef logic [5:0]  opcode;
	typedef logic [5:0]  funct;
	typedef logic [15:0] imm16;

	// Primary opcodes
	localparam opcode OP_RTYPE = 6'b000000;
	localparam opcode OP_ADDI  = 6'b001000;
	localparam opcode OP_LW    = 6'b100011;
	localparam opcode OP_SW    = 6'b101011;
	localparam opcode OP_BEQ   = 6'b000100;
	localparam opcode OP_BNE   = 6'b000101;
	localparam opcode OP_BGTZ  = 6'b000111;

	// R-type function codes
	localparam funct FN_ADD  = 6'b100000;
	localparam funct FN_ADDU = 6'b100001;
	localparam funct FN_SUB  = 6'b100010;
	localparam funct FN_SUBU = 6'b100011;
	localparam funct FN_AND  = 6'b100100;
	localparam funct FN_OR   = 6'b100101;
	localparam funct FN_SLL  = 6'b000000;
	localparam funct FN_SLT  = 6'b101010;
	localparam funct FN_SLTU = 6'b101011;

endpackage
